// File: verilog.f
+incdir+logic
logic/eth_pkg.sv
logic/board_pkg.sv
logic/lane_if.sv
logic/board_ctrl.sv
logic/lane_tx_gearbox.sv
logic/lane_rx_gearbox.sv
logic/fpga.sv
verification/fpga_checker.sv
verification/fpga_assertions.sv
verification/tb_fpga.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass message in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_fpga -f verilog.f -o tb_fpga_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fpga_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    exit 0
fi

echo "Pass message not found in sim.log"
exit 1

// File: verification/tb_fpga.sv
// Testbench for the board top level: reset, payload loopback, back-pressure, switch debounce
// Stimulus comes from xorshift with a fixed seed, fpga_checker does the comparing
`timescale 1ns/10ps
`include "fpga_macros.svh"

module tb_fpga;
    import eth_pkg::*;
    import board_pkg::*;

    localparam int RATE         = 4;
    localparam int PACKETS      = 40;
    localparam int MAX_BEATS    = `PAYLOAD_BYTES + 2 * PACKETS * `LANE_WORDS;
    localparam int DEBOUNCE_LEN = RATE + 3 * (6 * RATE + 2);
    localparam int CYCLE_LIMIT  = MAX_BEATS * 8 + DEBOUNCE_LEN + 500;

    logic          clk;
    logic          rst_n;
    sw_t           user_sw;
    led_g_t        user_led_g;
    logic          user_led_r;
    payload_data_t tx_payload_axis_tdata;
    payload_keep_t tx_payload_axis_tkeep;
    logic          tx_payload_axis_tvalid;
    logic          tx_payload_axis_tready;
    logic          tx_payload_axis_tlast;
    payload_data_t rx_payload_axis_tdata;
    payload_keep_t rx_payload_axis_tkeep;
    logic          rx_payload_axis_tvalid;
    logic          rx_payload_axis_tready;
    logic          rx_payload_axis_tlast;
    int            error_count;
    int            pending_count;

    logic [31:0] data_rng     = 32'd89;
    logic [31:0] ready_rng    = 32'd89;
    logic        random_ready = 1'b0;
    int          low_run      = 0;
    logic        stall_seen   = 1'b0;
    int          cycle_count  = 0;

    fpga #(.DEBOUNCE_RATE(RATE)) DUT (.*);

    fpga_checker scoreboard (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Expected output data: enabled bytes pass, disabled bytes read back as zero
    function automatic payload_data_t reference_data(input payload_data_t data,
                                                     input payload_keep_t keep);
        payload_data_t r;
        r = data;
        for (int b = 0; b < `PAYLOAD_BYTES; b++) begin
            if (!keep[b]) begin
                r[b*8 +: 8] = 8'h00;
            end
        end
        return r;
    endfunction

    function automatic payload_keep_t low_bytes(input int count);
        payload_keep_t k;
        k = '0;
        for (int b = 0; b < count; b++) begin
            k[b] = 1'b1;
        end
        return k;
    endfunction

    task automatic next_rand(output logic [31:0] value);
        data_rng = xorshift32(data_rng);
        value    = data_rng;
    endtask

    task automatic random_beat(output payload_data_t data);
        logic [31:0] w;
        for (int i = 0; i < `PAYLOAD_BYTES / 4; i++) begin
            next_rand(w);
            data[i*32 +: 32] = w;
        end
    endtask

    // Holds the beat until tready is seen in the low phase, returns on the transfer edge
    task automatic send_beat(input payload_data_t data, input payload_keep_t keep,
                             input logic last);
        logic taken;
        taken = 1'b0;
        tx_payload_axis_tdata  <= data;
        tx_payload_axis_tkeep  <= keep;
        tx_payload_axis_tlast  <= last;
        tx_payload_axis_tvalid <= 1'b1;
        scoreboard.expect_beat(reference_data(data, keep), keep, last);
        while (!taken) begin
            @(negedge clk);
            taken = tx_payload_axis_tready;
            @(posedge clk);
        end
    endtask

    task automatic random_packets(input int count);
        logic [31:0]   r;
        payload_data_t data;
        int            beats;
        for (int p = 0; p < count; p++) begin
            next_rand(r);
            beats = 2 + int'(r % 32'd3);
            for (int i = 0; i < beats; i++) begin
                random_beat(data);
                if (i == beats - 1) begin
                    send_beat(data, low_bytes(1 + int'((r >> 8) % 32'd32)), 1'b1);
                end else begin
                    send_beat(data, '1, 1'b0);
                end
            end
        end
        tx_payload_axis_tvalid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (pending_count != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
    endtask

    task automatic check_idle_outputs(input led_g_t exp_g);
        @(negedge clk);
        scoreboard.check_value("rx_payload_axis_tvalid", 256'(rx_payload_axis_tvalid), 256'(0));
        scoreboard.check_value("user_led_r", 256'(user_led_r), 256'(1));
        scoreboard.check_value("user_led_g", 256'(user_led_g), 256'(exp_g));
        @(posedge clk);
    endtask

    // Green LEDs must hold exp_g on every cycle of the window
    task automatic watch_led_g(input int cycles, input led_g_t exp_g);
        logic reported;
        reported = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (!reported && user_led_g !== exp_g) begin
                scoreboard.check_value("user_led_g", 256'(user_led_g), 256'(exp_g));
                reported = 1'b1;
            end
            @(posedge clk);
        end
    endtask

    // Output ready, random only during the back-pressure test
    initial begin
        rx_payload_axis_tready <= 1'b1;
        forever begin
            @(posedge clk);
            if (random_ready) begin
                ready_rng = xorshift32(ready_rng);
                rx_payload_axis_tready <= ready_rng[0];
            end else begin
                rx_payload_axis_tready <= 1'b1;
            end
        end
    end

    // A beat takes LANE_WORDS-1 low cycles at most, a longer run means tx ran out of credit
    always @(negedge clk) begin
        if (tx_payload_axis_tvalid && !tx_payload_axis_tready) begin
            low_run = low_run + 1;
        end else begin
            low_run = 0;
        end
        if (random_ready && low_run >= `LANE_WORDS) begin
            stall_seen = 1'b1;
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        payload_data_t data;
        rst_n                  <= 1'b0;
        user_sw                <= '0;
        tx_payload_axis_tdata  <= '0;
        tx_payload_axis_tkeep  <= '0;
        tx_payload_axis_tvalid <= 1'b0;
        tx_payload_axis_tlast  <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (`RESET_SYNC_STAGES + 2) @(posedge clk);
        check_idle_outputs('0);
        scoreboard.end_test("reset state");

        for (int n = 1; n <= `PAYLOAD_BYTES; n++) begin
            random_beat(data);
            send_beat(data, low_bytes(n), 1'b1);
        end
        tx_payload_axis_tvalid <= 1'b0;
        wait_drain();
        scoreboard.end_test("single-beat packets");

        random_packets(PACKETS);
        wait_drain();
        check_idle_outputs('0);
        scoreboard.end_test("multi-beat packets");

        random_ready <= 1'b1;
        random_packets(PACKETS);
        wait_drain();
        random_ready <= 1'b0;
        if (!stall_seen) begin
            scoreboard.report_failure("tx_payload_axis_tready never stalled under back-pressure");
        end
        scoreboard.end_test("back-pressure");

        // Pulse shorter than one sample period, then two held changes
        user_sw <= 2'b01;
        watch_led_g(RATE - 1, 2'b00);
        user_sw <= 2'b00;
        watch_led_g(6 * RATE, 2'b00);
        check_idle_outputs(2'b00);
        user_sw <= 2'b10;
        repeat (6 * RATE) @(posedge clk);
        check_idle_outputs(2'b10);
        user_sw <= 2'b01;
        repeat (6 * RATE) @(posedge clk);
        check_idle_outputs(2'b01);
        scoreboard.end_test("switch debounce");

        scoreboard.report_totals();
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: verification/fpga_assertions.sv
// Lane credit and output handshake properties, bound into the board top level
`timescale 1ns/10ps
`include "fpga_macros.svh"

module fpga_assertions (
    input logic                   clk,
    input logic                   rst_sync,
    input logic                   lane_valid,
    input logic                   lane_credit,
    input eth_pkg::credit_t       credit_cnt,
    input logic                   rx_tvalid,
    input logic                   rx_tready,
    input eth_pkg::payload_data_t rx_tdata,
    input logic                   rx_tlast
);
    import eth_pkg::*;

    // Words on the lane or in the rx buffer, counted from the lane signals alone
    int in_flight;

    always_ff @(posedge clk or posedge rst_sync) begin
        if (rst_sync) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(lane_valid) - int'(lane_credit);
        end
    end

    // Tx side of the lane
    valid_needs_credit: assert property (@(posedge clk) disable iff (rst_sync)
        lane_valid |-> in_flight < `LANE_FIFO_DEPTH)
        else $error("lane valid raised with zero credits left");

    credit_in_range: assert property (@(posedge clk) disable iff (rst_sync)
        credit_cnt <= credit_t'(`LANE_FIFO_DEPTH))
        else $error("credit count above receive buffer depth");

    // Held output beat must not move
    rx_beat_held: assert property (@(posedge clk) disable iff (rst_sync)
        rx_tvalid && !rx_tready |=> rx_tvalid && $stable(rx_tdata) && $stable(rx_tlast))
        else $error("rx beat changed before it was taken");

endmodule

bind fpga fpga_assertions assertions_inst (
    .clk         (clk),
    .rst_sync    (rst_sync),
    .lane_valid  (lane.valid),
    .lane_credit (lane.credit),
    .credit_cnt  (lane_tx_gearbox_inst.credit_cnt),
    .rx_tvalid   (rx_payload_axis_tvalid),
    .rx_tready   (rx_payload_axis_tready),
    .rx_tdata    (rx_payload_axis_tdata),
    .rx_tlast    (rx_payload_axis_tlast)
);

// File: verification/fpga_checker.sv
// Scoreboard for the payload loopback, plus value checks requested by the testbench
// Expected beats are queued through expect_beat, output transfers are compared as they happen
`timescale 1ns/10ps

module fpga_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  eth_pkg::payload_data_t rx_payload_axis_tdata,
    input  eth_pkg::payload_keep_t rx_payload_axis_tkeep,
    input  logic                   rx_payload_axis_tvalid,
    input  logic                   rx_payload_axis_tready,
    input  logic                   rx_payload_axis_tlast,
    output int                     error_count,
    output int                     pending_count
);
    import eth_pkg::*;

    payload_data_t exp_data [$];
    payload_keep_t exp_keep [$];
    logic          exp_last [$];

    // Stream side counters belong to the compare process, the rest to the task callers
    int stream_errors = 0;
    int beats_seen    = 0;
    int check_errors  = 0;
    int pushed        = 0;
    int tests_run     = 0;
    int tests_failed  = 0;
    int mark_errors   = 0;
    int mark_beats    = 0;

    assign error_count   = stream_errors + check_errors;
    assign pending_count = pushed - beats_seen;

    function automatic int mismatch(input string name, input logic [255:0] actual,
                                    input logic [255:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            return 1;
        end
        return 0;
    endfunction

    task automatic expect_beat(input payload_data_t data, input payload_keep_t keep,
                               input logic last);
        exp_data.push_back(data);
        exp_keep.push_back(keep);
        exp_last.push_back(last);
        pushed++;
    endtask

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        check_errors += mismatch(name, actual, expected);
    endtask

    task automatic report_failure(input string what);
        $display("Error: %s", what);
        check_errors++;
    endtask

    // Outputs are steady in the low phase, the transfer itself is on the next rising edge
    always @(negedge clk) begin : compare
        payload_data_t d;
        payload_keep_t k;
        logic          l;
        if (rst_n && rx_payload_axis_tvalid && rx_payload_axis_tready) begin
            if (exp_data.size() == 0) begin
                $display("Error: output beat arrived with no beat outstanding");
                stream_errors++;
            end else begin
                d = exp_data.pop_front();
                k = exp_keep.pop_front();
                l = exp_last.pop_front();
                stream_errors += mismatch("rx_payload_axis_tdata", rx_payload_axis_tdata, d);
                stream_errors += mismatch("rx_payload_axis_tkeep",
                                          256'(rx_payload_axis_tkeep), 256'(k));
                stream_errors += mismatch("rx_payload_axis_tlast",
                                          256'(rx_payload_axis_tlast), 256'(l));
                beats_seen++;
            end
        end
    end

    task automatic end_test(input string name);
        int errs;
        int beats;
        if (pushed != beats_seen) begin
            report_failure($sformatf("%0d beats never came out", pushed - beats_seen));
        end
        errs  = stream_errors + check_errors - mark_errors;
        beats = beats_seen - mark_beats;
        tests_run++;
        if (errs == 0) begin
            $display("Test %0d %s: passed, %0d beats", tests_run, name, beats);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed, %0d errors, %0d beats", tests_run, name, errs, beats);
        end
        mark_errors = stream_errors + check_errors;
        mark_beats  = beats_seen;
    endtask

    task automatic report_totals();
        $display("Summary: %0d tests, %0d failed, %0d beats compared, %0d errors",
                 tests_run, tests_failed, beats_seen, stream_errors + check_errors);
    endtask

endmodule

// File: logic/fpga.sv
// Board top level: reset and switch handling plus the looped-back payload lane
// Payload enters on tx_payload_axis, crosses one 64-bit lane, leaves on rx_payload_axis
`timescale 1ns/10ps
`include "fpga_macros.svh"

module fpga #(
    parameter int DEBOUNCE_RATE = `DEBOUNCE_RATE
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // GPIO
    input  board_pkg::sw_t         user_sw,
    output board_pkg::led_g_t      user_led_g,
    output logic                   user_led_r,

    // Payload in
    input  eth_pkg::payload_data_t tx_payload_axis_tdata,
    input  eth_pkg::payload_keep_t tx_payload_axis_tkeep,
    input  logic                   tx_payload_axis_tvalid,
    output logic                   tx_payload_axis_tready,
    input  logic                   tx_payload_axis_tlast,

    // Payload out
    output eth_pkg::payload_data_t rx_payload_axis_tdata,
    output eth_pkg::payload_keep_t rx_payload_axis_tkeep,
    output logic                   rx_payload_axis_tvalid,
    input  logic                   rx_payload_axis_tready,
    output logic                   rx_payload_axis_tlast
);

    logic rst_sync;
    logic path_idle;

    lane_if lane ();

    board_ctrl #(
        .RATE(DEBOUNCE_RATE)
    ) board_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .user_sw    (user_sw),
        .path_idle  (path_idle),
        .rst_sync   (rst_sync),
        .user_led_g (user_led_g),
        .user_led_r (user_led_r)
    );

    lane_tx_gearbox lane_tx_gearbox_inst (
        .clk                    (clk),
        .rst_sync               (rst_sync),
        .tx_payload_axis_tdata  (tx_payload_axis_tdata),
        .tx_payload_axis_tkeep  (tx_payload_axis_tkeep),
        .tx_payload_axis_tvalid (tx_payload_axis_tvalid),
        .tx_payload_axis_tlast  (tx_payload_axis_tlast),
        .tx_payload_axis_tready (tx_payload_axis_tready),
        .lane                   (lane.tx)
    );

    // Stands in for the looped-back XGMII lane
    lane_rx_gearbox lane_rx_gearbox_inst (
        .clk                    (clk),
        .rst_sync               (rst_sync),
        .rx_payload_axis_tdata  (rx_payload_axis_tdata),
        .rx_payload_axis_tkeep  (rx_payload_axis_tkeep),
        .rx_payload_axis_tvalid (rx_payload_axis_tvalid),
        .rx_payload_axis_tready (rx_payload_axis_tready),
        .rx_payload_axis_tlast  (rx_payload_axis_tlast),
        .path_idle              (path_idle),
        .lane                   (lane.rx)
    );

endmodule

// File: logic/lane_rx_gearbox.sv
// Buffers lane words and regathers them into 256-bit payload beats
// Every word taken out of the buffer returns one credit to the tx side
`timescale 1ns/10ps
`include "fpga_macros.svh"

module lane_rx_gearbox (
    input  logic                   clk,
    input  logic                   rst_sync,
    output eth_pkg::payload_data_t rx_payload_axis_tdata,
    output eth_pkg::payload_keep_t rx_payload_axis_tkeep,
    output logic                   rx_payload_axis_tvalid,
    input  logic                   rx_payload_axis_tready,
    output logic                   rx_payload_axis_tlast,
    output logic                   path_idle,
    lane_if.rx                     lane
);
    import eth_pkg::*;

    localparam int PTR_W  = $clog2(`LANE_FIFO_DEPTH);
    localparam int IDX_W  = $clog2(`LANE_WORDS);
    localparam int DATA_W = `LANE_BYTES * 8;

    lane_word_t       buf_mem [`LANE_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_t          fill;
    lane_word_t       head;
    logic             pop;
    logic             beat_done;
    logic [IDX_W-1:0] word_idx;
    payload_data_t    next_data;
    payload_keep_t    next_keep;

    // No overflow check, the credit count bounds the fill level
    always_ff @(posedge clk) begin
        if (lane.valid) begin
            buf_mem[wr_ptr] <= lane.word;
        end
    end

    assign head = buf_mem[rd_ptr];

    // Stall while a finished beat waits on the output
    assign pop       = (fill != '0) && (!rx_payload_axis_tvalid || rx_payload_axis_tready);
    assign beat_done = head.last || (word_idx == IDX_W'(`LANE_WORDS - 1));

    assign lane.credit = pop;
    assign path_idle   = (fill == '0) && (word_idx == '0) && !rx_payload_axis_tvalid;

    // First word of a beat clears the slots above it
    always_comb begin
        next_data = (word_idx == '0) ? '0 : rx_payload_axis_tdata;
        next_keep = (word_idx == '0) ? '0 : rx_payload_axis_tkeep;
        next_data[word_idx*DATA_W +: DATA_W]           = head.data;
        next_keep[word_idx*`LANE_BYTES +: `LANE_BYTES] = head.keep;
    end

    always_ff @(posedge clk or posedge rst_sync) begin
        if (rst_sync) begin
            wr_ptr                 <= '0;
            rd_ptr                 <= '0;
            fill                   <= '0;
            word_idx               <= '0;
            rx_payload_axis_tvalid <= 1'b0;
        end else begin
            if (lane.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({lane.valid, pop})
                2'b10:   fill <= fill + credit_t'(1);
                2'b01:   fill <= fill - credit_t'(1);
                default: fill <= fill;
            endcase

            if (pop) begin
                rx_payload_axis_tvalid <= beat_done;
                word_idx               <= beat_done ? '0 : word_idx + 1'b1;
            end else if (rx_payload_axis_tready) begin
                rx_payload_axis_tvalid <= 1'b0;
            end
        end
    end

    // Gathering register doubles as the output beat
    always_ff @(posedge clk) begin
        if (pop) begin
            rx_payload_axis_tdata <= next_data;
            rx_payload_axis_tkeep <= next_keep;
            rx_payload_axis_tlast <= head.last;
        end
    end

endmodule

// File: logic/lane_tx_gearbox.sv
// Splits 256-bit payload beats into 64-bit lane words, low bytes first
// Sends only while credits remain; one credit per word, returned by the rx side
`timescale 1ns/10ps
`include "fpga_macros.svh"

module lane_tx_gearbox (
    input  logic                   clk,
    input  logic                   rst_sync,
    input  eth_pkg::payload_data_t tx_payload_axis_tdata,
    input  eth_pkg::payload_keep_t tx_payload_axis_tkeep,
    input  logic                   tx_payload_axis_tvalid,
    input  logic                   tx_payload_axis_tlast,
    output logic                   tx_payload_axis_tready,
    lane_if.tx                     lane
);
    import eth_pkg::*;

    localparam int IDX_W  = $clog2(`LANE_WORDS);
    localparam int DATA_W = `LANE_BYTES * 8;

    payload_data_t    beat_data;
    payload_keep_t    beat_keep;
    logic             beat_last;
    logic             beat_held;
    logic [IDX_W-1:0] word_idx;
    credit_t          credit_cnt;
    logic             active;
    logic             upper_empty;
    logic             final_word;
    logic             send;
    logic             take;
    lane_data_t       word_data;
    lane_keep_t       word_keep;

    // On the last beat, trailing words with no valid bytes are not sent
    always_comb begin
        upper_empty = 1'b1;
        for (int i = 0; i < `LANE_WORDS; i++) begin
            if (i > int'(word_idx) && beat_keep[i*`LANE_BYTES +: `LANE_BYTES] != '0) begin
                upper_empty = 1'b0;
            end
        end
    end

    assign final_word = (word_idx == IDX_W'(`LANE_WORDS - 1)) || (beat_last && upper_empty);
    assign send       = beat_held && (credit_cnt != '0);

    // Next beat may load on the cycle the held one sends its final word
    assign tx_payload_axis_tready = active && (!beat_held || (send && final_word));
    assign take                   = tx_payload_axis_tvalid && tx_payload_axis_tready;

    // Current slice, with disabled bytes zeroed
    always_comb begin
        word_data = beat_data[word_idx*DATA_W +: DATA_W];
        word_keep = beat_keep[word_idx*`LANE_BYTES +: `LANE_BYTES];
        for (int b = 0; b < `LANE_BYTES; b++) begin
            if (!word_keep[b]) begin
                word_data[b*8 +: 8] = 8'h00;
            end
        end
    end

    assign lane.valid = send;
    assign lane.word  = '{data: word_data, keep: word_keep, last: beat_last && final_word};

    always_ff @(posedge clk or posedge rst_sync) begin
        if (rst_sync) begin
            active     <= 1'b0;
            beat_held  <= 1'b0;
            word_idx   <= '0;
            credit_cnt <= credit_t'(`LANE_FIFO_DEPTH);
        end else begin
            active <= 1'b1;
            if (take) begin
                beat_held <= 1'b1;
                word_idx  <= '0;
            end else if (send) begin
                if (final_word) begin
                    beat_held <= 1'b0;
                end else begin
                    word_idx <= word_idx + 1'b1;
                end
            end
            case ({send, lane.credit})
                2'b10:   credit_cnt <= credit_cnt - credit_t'(1);
                2'b01:   credit_cnt <= credit_cnt + credit_t'(1);
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            beat_data <= tx_payload_axis_tdata;
            beat_keep <= tx_payload_axis_tkeep;
            beat_last <= tx_payload_axis_tlast;
        end
    end

endmodule

// File: logic/board_ctrl.sv
// Reset synchronizer, switch debouncer and status LED registers
// rst_sync is the active-high reset for the rest of the design
`timescale 1ns/10ps
`include "fpga_macros.svh"

module board_ctrl #(
    parameter int RATE = `DEBOUNCE_RATE
) (
    input  logic              clk,
    input  logic              rst_n,
    input  board_pkg::sw_t    user_sw,
    input  logic              path_idle,
    output logic              rst_sync,
    output board_pkg::led_g_t user_led_g,
    output logic              user_led_r
);
    import board_pkg::*;

    localparam int CNT_W = $clog2(RATE + 1);

    logic [`RESET_SYNC_STAGES-1:0] sync_q;
    logic [CNT_W-1:0]              rate_cnt;
    logic                          sample_tick;
    logic [`DEBOUNCE_DEPTH-1:0]    sw_hist [`SW_COUNT];
    sw_t                           sw_db;

    // Assert at once, release after the chain has filled with zeros
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[`RESET_SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign rst_sync = sync_q[`RESET_SYNC_STAGES-1];

    // Sample strobe every RATE cycles
    assign sample_tick = (rate_cnt == CNT_W'(RATE - 1));

    always_ff @(posedge clk or posedge rst_sync) begin
        if (rst_sync) begin
            rate_cnt <= '0;
        end else if (sample_tick) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    // Output only moves once the whole history agrees
    always_ff @(posedge clk or posedge rst_sync) begin
        if (rst_sync) begin
            for (int i = 0; i < `SW_COUNT; i++) begin
                sw_hist[i] <= '0;
            end
            sw_db <= '0;
        end else if (sample_tick) begin
            for (int i = 0; i < `SW_COUNT; i++) begin
                sw_hist[i] <= {sw_hist[i][`DEBOUNCE_DEPTH-2:0], user_sw[i]};
                if (&sw_hist[i]) begin
                    sw_db[i] <= 1'b1;
                end else if (~|sw_hist[i]) begin
                    sw_db[i] <= 1'b0;
                end
            end
        end
    end

    // Red LED lit while the path is empty, and through reset
    always_ff @(posedge clk or posedge rst_sync) begin
        if (rst_sync) begin
            user_led_g <= '0;
            user_led_r <= 1'b1;
        end else begin
            user_led_g <= led_g_t'(sw_db);
            user_led_r <= path_idle;
        end
    end

endmodule

// File: logic/lane_if.sv
// Single 64-bit lane between the tx and rx gearboxes, with credit return
// Tx may only send while it holds credit, so there is no ready
`timescale 1ns/10ps

interface lane_if;
    import eth_pkg::*;

    lane_word_t word;
    logic       valid;
    // One pulse per word drained from the rx buffer
    logic       credit;

    modport tx (
        output word,
        output valid,
        input  credit
    );

    modport rx (
        input  word,
        input  valid,
        output credit
    );

endinterface

// File: logic/board_pkg.sv
// Types for the switch inputs and status LEDs of the board-control logic
`include "fpga_macros.svh"

package board_pkg;

    // Raw or debounced switch vector
    typedef logic [`SW_COUNT-1:0] sw_t;

    // Green user LEDs
    typedef logic [1:0] led_g_t;

endpackage

// File: logic/eth_pkg.sv
// Data path types shared by the payload ports, the lane interface and both gearboxes
// Import inside a module body, use eth_pkg::name in port lists
`include "fpga_macros.svh"

package eth_pkg;

    // One payload beat on the outer streams
    typedef logic [`PAYLOAD_BYTES*8-1:0] payload_data_t;
    typedef logic [`PAYLOAD_BYTES-1:0]   payload_keep_t;

    // One word on the 64-bit lane
    typedef logic [`LANE_BYTES*8-1:0] lane_data_t;
    typedef logic [`LANE_BYTES-1:0]   lane_keep_t;

    // Lane word as it travels between the gearboxes
    typedef struct packed {
        lane_data_t data;
        lane_keep_t keep;
        logic       last;  // final word of a packet
    } lane_word_t;

    // Must reach LANE_FIFO_DEPTH, so one bit more than the buffer index
    typedef logic [$clog2(`LANE_FIFO_DEPTH+1)-1:0] credit_t;

endpackage

// File: logic/fpga_macros.svh
// Board-level sizing for the payload lane and the switch and reset logic
// Included by the packages and by every RTL module that needs a number
`ifndef FPGA_MACROS_SVH
`define FPGA_MACROS_SVH

// Payload path
`define PAYLOAD_BYTES 32
`define LANE_BYTES 8
`define LANE_WORDS 4

// Receive buffer depth, also the credits tx starts with
`define LANE_FIFO_DEPTH 8

// Board control
`define RESET_SYNC_STAGES 4
`define DEBOUNCE_RATE 125000
`define DEBOUNCE_DEPTH 4
`define SW_COUNT 2

`endif
